// File: ahb_in_pkg.sv
// AHB input stage package with bus encodings, field widths and the transfer struct
package ahb_in_pkg;

  // ----------------------------------------
  // Field widths
  // ----------------------------------------
  localparam int ADDR_W   = 32;  // HADDR
  localparam int TRANS_W  = 2;   // HTRANS
  localparam int SIZE_W   = 3;   // HSIZE
  localparam int BURST_W  = 3;   // HBURST
  localparam int PROT_W   = 4;   // HPROT
  localparam int MASTER_W = 4;   // HMASTER
  localparam int RESP_W   = 2;   // HRESP

  // ----------------------------------------
  // Encodings
  // ----------------------------------------
  // Transfer type, bit 1 marks an active transfer
  typedef enum logic [TRANS_W-1:0] {
    TRN_IDLE   = 2'b00,  // No transfer
    TRN_BUSY   = 2'b01,  // Master inserting a wait in a burst
    TRN_NONSEQ = 2'b10,  // First beat or single
    TRN_SEQ    = 2'b11   // Following beat of a burst
  } trn_t;

  // Burst type
  typedef enum logic [BURST_W-1:0] {
    BUR_SINGLE = 3'b000,
    BUR_INCR   = 3'b001,  // Undefined length
    BUR_WRAP4  = 3'b010,
    BUR_INCR4  = 3'b011,
    BUR_WRAP8  = 3'b100,
    BUR_INCR8  = 3'b101,
    BUR_WRAP16 = 3'b110,
    BUR_INCR16 = 3'b111
  } bur_t;

  // Slave responses in use
  localparam logic [RESP_W-1:0] RSP_OKAY  = 2'b00;
  localparam logic [RESP_W-1:0] RSP_ERROR = 2'b01;

  // ----------------------------------------
  // Address phase bundle
  // ----------------------------------------
  // Everything the master drives in the address phase, except HSEL
  typedef struct packed {
    trn_t                trans;     // HTRANS
    logic [ADDR_W-1:0]   addr;      // HADDR
    logic                write;     // HWRITE
    logic [SIZE_W-1:0]   size;      // HSIZE
    bur_t                burst;     // HBURST
    logic [PROT_W-1:0]   prot;      // HPROT
    logic [MASTER_W-1:0] master;    // HMASTER
    logic                mastlock;  // HMASTLOCK
  } ahb_ctrl_t;

endpackage

// File: ahb_hold_if.sv
// Hold control bundle shared by the pending controller and the datapath blocks
interface ahb_hold_if;

  // Strobes from the pending controller
  logic load;    // Accepted address phase, capture it
  logic pend;    // Transfer waiting in the holding register

  // Levels from the bus side
  logic hready;  // HREADY of the input port
  logic active;  // Output stage is taking this port

  // ----------------------------------------
  // Views
  // ----------------------------------------
  // Controller owns load and pend
  modport ctl (
    output load,
    output pend,
    input  hready,
    input  active
  );

  // Datapath blocks only look
  modport user (
    input load,
    input pend,
    input hready,
    input active
  );

endinterface

// File: ahb_pend_ctrl.sv
// Pending transfer controller with load strobe, data phase flag and response mux
module ahb_pend_ctrl
  import ahb_in_pkg::*;
(
  input  logic              HCLK,
  input  logic              HRESETn,
  input  logic              hsel,         // Port select from the master
  input  trn_t              trans,        // Raw transfer type
  ahb_hold_if.ctl           hold,
  input  logic              readyout_ip,  // Ready from the shared slave
  input  logic [RESP_W-1:0] resp_ip,      // Response from the shared slave
  output logic              held_tran,    // Request to the output stage
  output logic              hreadyout,    // Ready back to the master
  output logic [RESP_W-1:0] hresp         // Response back to the master
);

  logic addr_valid;  // Active address phase on this port
  logic data_valid;  // Data phase of an accepted transfer
  logic pend_q;      // Held transfer not yet completed
  logic pend_next;

  // ----------------------------------------
  // Address phase strobes
  // ----------------------------------------
  assign addr_valid = hsel & trans[1];          // NONSEQ or SEQ only
  assign hold.load  = addr_valid & hold.hready;  // Master moved on, capture

  // Data phase flag, frozen while the bus is stalled
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (hold.hready)
      data_valid <= addr_valid;
  end

  // ----------------------------------------
  // Pending transfer
  // ----------------------------------------
  // Set has priority over clear
  always_comb
  begin
    if (hold.load && !hold.active)
      pend_next = 1'b1;                // Output stage busy elsewhere
    else if (hold.active && readyout_ip)
      pend_next = 1'b0;                // Slave finished the replay
    else
      pend_next = pend_q;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pend_q <= 1'b0;
    else
      pend_q <= pend_next;
  end

  assign hold.pend = pend_q;
  assign held_tran = hold.load | pend_q;  // Direct or replayed request

  // ----------------------------------------
  // Response mux
  // ----------------------------------------
  always_comb
  begin
    if (!data_valid)
    begin
      hreadyout = 1'b1;   // Idle, busy or unselected
      hresp     = RSP_OKAY;
    end
    else if (pend_q)
    begin
      hreadyout = 1'b0;   // Stall until replay completes
      hresp     = RSP_OKAY;
    end
    else
    begin
      hreadyout = readyout_ip;
      hresp     = resp_ip;
    end
  end

  // Held transfer keeps its data phase open so the stall stays visible
  a_pend_in_data : assert property (@(posedge HCLK) disable iff (!HRESETn)
    pend_q |-> data_valid);

endmodule

// File: ahb_hold_reg.sv
// Holding register for the address phase and the held/direct select mux
module ahb_hold_reg
  import ahb_in_pkg::*;
(
  input  logic      HCLK,
  input  logic      HRESETn,
  ahb_hold_if.user  hold,
  input  logic      hsel,       // Port select from the master
  input  ahb_ctrl_t in_ctrl,    // Raw address phase
  output logic      sel_ip,     // Select towards the output stage
  output ahb_ctrl_t cur,        // Selected address phase
  output trn_t      src_trans   // Transfer type before the NONSEQ rewrite
);

  ahb_ctrl_t hold_q;  // Captured address phase

  // ----------------------------------------
  // Capture
  // ----------------------------------------
  // Loaded on every accepted transfer, only read back while pend is set
  always_ff @(posedge HCLK)
  begin
    if (hold.load)
      hold_q <= in_ctrl;
  end

  // ----------------------------------------
  // Output select
  // ----------------------------------------
  always_comb
  begin
    if (hold.pend)
    begin
      sel_ip    = 1'b1;          // Replay always selects the slave
      cur       = hold_q;
      cur.trans = TRN_NONSEQ;    // Replay starts a fresh transfer
      src_trans = hold_q.trans;  // Keep burst history for the fixup
    end
    else
    begin
      sel_ip    = hsel;          // Straight through
      cur       = in_ctrl;
      src_trans = in_ctrl.trans;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  // Held transfer is not overwritten while it is replayed
  a_no_load_in_pend : assert property (@(posedge HCLK) disable iff (!HRESETn)
    hold.pend |-> !hold.load);

  // Replay starts with the address accepted on the cycle before
  a_replay_addr : assert property (@(posedge HCLK) disable iff (!HRESETn)
    $rose(hold.pend) |-> (cur.addr == $past(in_ctrl.addr)) &&
                         (cur.write == $past(in_ctrl.write)));

endmodule

// File: ahb_burst_fix.sv
// Early burst termination and wrap boundary fixup of HTRANS and HBURST
module ahb_burst_fix
  import ahb_in_pkg::*;
(
  input  logic      HCLK,
  input  logic      HRESETn,
  ahb_hold_if.user  hold,
  input  ahb_ctrl_t in_ctrl,    // Raw address phase
  input  ahb_ctrl_t cur,        // Selected address phase
  input  trn_t      src_trans,  // Untouched type of the selected transfer
  output trn_t      trans_ip,   // HTRANS to the output stage
  output bur_t      burst_ip    // HBURST to the output stage
);

  logic       override_q;     // Burst broken off, finish it as INCR
  logic       override_next;
  logic [3:0] offset_addr;    // Beat index within a 16 beat window
  logic [3:0] check_addr;     // Ones above the wrap length
  logic       bound_next;     // Last beat before the wrap point
  logic       bound_en;
  logic       bound_q;

  // ----------------------------------------
  // Early burst termination
  // ----------------------------------------
  always_comb
  begin
    if ((in_ctrl.trans == TRN_NONSEQ) || (in_ctrl.trans == TRN_IDLE))
      override_next = 1'b0;                   // New burst or none
    else if ((in_ctrl.trans == TRN_SEQ) && hold.load && !hold.active)
      override_next = 1'b1;                   // Burst cut by the arbiter
    else
      override_next = override_q;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      override_q <= 1'b0;
    else if (hold.hready)
      override_q <= override_next;
  end

  // ----------------------------------------
  // Wrap boundary detection
  // ----------------------------------------
  // Address bits that count beats for the transfer size
  always_comb
  begin
    case (in_ctrl.size)
      3'b000:  offset_addr = in_ctrl.addr[3:0];  // Byte
      3'b001:  offset_addr = in_ctrl.addr[4:1];  // Halfword
      3'b010:  offset_addr = in_ctrl.addr[5:2];  // Word
      3'b011:  offset_addr = in_ctrl.addr[6:3];  // Doubleword
      default: offset_addr = in_ctrl.addr[3:0];  // 128 bits and wider
    endcase
  end

  // Pad unused index bits with ones so only the wrap beat matches
  always_comb
  begin
    case (in_ctrl.burst)
      BUR_WRAP4:  check_addr = {2'b11, offset_addr[1:0]};
      BUR_WRAP8:  check_addr = {1'b1, offset_addr[2:0]};
      BUR_WRAP16: check_addr = offset_addr;
      default:    check_addr = 4'b0000;  // Incrementing bursts never wrap
    endcase
  end

  assign bound_next = (check_addr == 4'b1111);
  assign bound_en   = in_ctrl.trans[1] & hold.hready;  // Active beat taken

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      bound_q <= 1'b0;
    else if (bound_en)
      bound_q <= bound_next;
  end

  // ----------------------------------------
  // Output rewrite
  // ----------------------------------------
  // SEQ becomes NONSEQ and BUSY becomes IDLE across the wrap point
  assign trans_ip = (override_q && bound_q) ? trn_t'({cur.trans[1], 1'b0})
                                            : cur.trans;

  // Rest of a broken burst carries on as undefined length
  assign burst_ip = (override_q && (src_trans != TRN_NONSEQ)) ? BUR_INCR
                                                              : cur.burst;

  // Override only starts when the cut beat went into the holding register
  a_ovr_with_pend : assert property (@(posedge HCLK) disable iff (!HRESETn)
    $rose(override_q) |-> hold.pend);

endmodule

// File: ahb_input_stage.sv
// AHB bus matrix input stage that holds transfers the output stage cannot take
module ahb_input_stage
  import ahb_in_pkg::*;
(
  input  logic                HCLK,
  input  logic                HRESETn,

  // Master side address phase
  input  logic                hsel_s,
  input  logic [ADDR_W-1:0]   haddr_s,
  input  logic [TRANS_W-1:0]  htrans_s,
  input  logic                hwrite_s,
  input  logic [SIZE_W-1:0]   hsize_s,
  input  logic [BURST_W-1:0]  hburst_s,
  input  logic [PROT_W-1:0]   hprot_s,
  input  logic [MASTER_W-1:0] hmaster_s,
  input  logic                hmastlock_s,
  input  logic                hready_s,

  // Output stage feedback
  input  logic                active_ip,
  input  logic                readyout_ip,
  input  logic [RESP_W-1:0]   resp_ip,

  // Master side response
  output logic                hreadyout_s,
  output logic [RESP_W-1:0]   hresp_s,

  // Towards the output stage
  output logic                sel_ip,
  output logic [ADDR_W-1:0]   addr_ip,
  output logic [TRANS_W-1:0]  trans_ip,
  output logic                write_ip,
  output logic [SIZE_W-1:0]   size_ip,
  output logic [BURST_W-1:0]  burst_ip,
  output logic [PROT_W-1:0]   prot_ip,
  output logic [MASTER_W-1:0] master_ip,
  output logic                mastlock_ip,
  output logic                held_tran_ip
);

  ahb_ctrl_t in_ctrl;    // Packed master fields
  ahb_ctrl_t cur;        // Held or direct transfer
  trn_t      src_trans;  // Type before the replay rewrite

  ahb_hold_if hold ();

  assign hold.hready = hready_s;
  assign hold.active = active_ip;

  // ----------------------------------------
  // Pack master side
  // ----------------------------------------
  assign in_ctrl.trans    = trn_t'(htrans_s);
  assign in_ctrl.addr     = haddr_s;
  assign in_ctrl.write    = hwrite_s;
  assign in_ctrl.size     = hsize_s;
  assign in_ctrl.burst    = bur_t'(hburst_s);
  assign in_ctrl.prot     = hprot_s;
  assign in_ctrl.master   = hmaster_s;
  assign in_ctrl.mastlock = hmastlock_s;

  // ----------------------------------------
  // Blocks
  // ----------------------------------------
  ahb_pend_ctrl u_pend_ctrl (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .hsel        (hsel_s),
    .trans       (in_ctrl.trans),
    .hold        (hold),
    .readyout_ip (readyout_ip),
    .resp_ip     (resp_ip),
    .held_tran   (held_tran_ip),
    .hreadyout   (hreadyout_s),
    .hresp       (hresp_s)
  );

  ahb_hold_reg u_hold_reg (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hold      (hold),
    .hsel      (hsel_s),
    .in_ctrl   (in_ctrl),
    .sel_ip    (sel_ip),
    .cur       (cur),
    .src_trans (src_trans)
  );

  ahb_burst_fix u_burst_fix (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hold      (hold),
    .in_ctrl   (in_ctrl),
    .cur       (cur),
    .src_trans (src_trans),
    .trans_ip  (trans_ip),
    .burst_ip  (burst_ip)
  );

  // Unpack towards the output stage, trans and burst come from the fixup
  assign addr_ip     = cur.addr;
  assign write_ip    = cur.write;
  assign size_ip     = cur.size;
  assign prot_ip     = cur.prot;
  assign master_ip   = cur.master;
  assign mastlock_ip = cur.mastlock;

endmodule

// File: tb_ahb_input_stage.sv
// Testbench for the AHB input stage with a rule model, directed beats and assertions
module tb_ahb_input_stage
  import ahb_in_pkg::*;
;

  logic HCLK;
  logic HRESETn;
  logic hsel_s, hwrite_s, hmastlock_s, hready_s, active_ip, readyout_ip;
  logic [ADDR_W-1:0]   haddr_s;
  logic [TRANS_W-1:0]  htrans_s;
  logic [SIZE_W-1:0]   hsize_s;
  logic [BURST_W-1:0]  hburst_s;
  logic [PROT_W-1:0]   hprot_s;
  logic [MASTER_W-1:0] hmaster_s;
  logic [RESP_W-1:0]   resp_ip;
  logic hreadyout_s, sel_ip, write_ip, mastlock_ip, held_tran_ip;
  logic [RESP_W-1:0]   hresp_s;
  logic [ADDR_W-1:0]   addr_ip;
  logic [TRANS_W-1:0]  trans_ip;
  logic [SIZE_W-1:0]   size_ip;
  logic [BURST_W-1:0]  burst_ip;
  logic [PROT_W-1:0]   prot_ip;
  logic [MASTER_W-1:0] master_ip;

  int err_cnt  = 0;  // Assertion failures so far
  int test_cnt = 0;
  int fail_cnt = 0;  // Tests with at least one failure
  int errs_at_start;

  ahb_input_stage dut0 (.*);

  // ----------------------------------------
  // Expected state from the bus rules
  // ----------------------------------------
  logic exp_pend, exp_data, exp_ovr, exp_bound;
  logic [TRANS_W-1:0] hold_trans;
  logic [ADDR_W-1:0]  hold_addr;
  logic [SIZE_W-1:0]  hold_size;
  logic [BURST_W-1:0] hold_burst;
  logic [PROT_W-1:0]  hold_prot;
  logic [MASTER_W-1:0] hold_master;
  logic hold_write, hold_lock;
  logic accept;                    // Valid address phase taken by the master
  logic [TRANS_W-1:0] cur_trans;   // Type on the output before any wrap rewrite
  logic [TRANS_W-1:0] src_type;    // Type as the master issued it

  assign accept    = hsel_s & htrans_s[1] & hready_s;
  assign cur_trans = exp_pend ? TRN_NONSEQ : htrans_s;  // Replay is always NONSEQ
  assign src_type  = exp_pend ? hold_trans : htrans_s;

  // Last beat of a wrapping burst before the address wraps
  function automatic logic wrap_last(input logic [ADDR_W-1:0] addr,
                                     input logic [SIZE_W-1:0] size,
                                     input logic [BURST_W-1:0] burst);
    logic [ADDR_W-1:0] beat;
    int len;
    beat = (size < 4) ? (addr >> size) : addr;  // Wide sizes count bytes
    case (burst)
      BUR_WRAP4:  len = 4;
      BUR_WRAP8:  len = 8;
      BUR_WRAP16: len = 16;
      default:    len = 0;
    endcase
    if (len == 0)
      return 1'b0;
    return (beat % len) == (len - 1);
  endfunction

  always @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      exp_pend  <= 1'b0;
      exp_data  <= 1'b0;
      exp_ovr   <= 1'b0;
      exp_bound <= 1'b0;
    end
    else
    begin
      if (accept && !active_ip)
        exp_pend <= 1'b1;                   // Output stage busy, hold it
      else if (active_ip && readyout_ip)
        exp_pend <= 1'b0;
      if (hready_s)
        exp_data <= hsel_s & htrans_s[1];
      if (hready_s && (htrans_s == TRN_NONSEQ || htrans_s == TRN_IDLE))
        exp_ovr <= 1'b0;
      else if (accept && htrans_s == TRN_SEQ && !active_ip)
        exp_ovr <= 1'b1;                    // Burst cut short
      if (hready_s && htrans_s[1])
        exp_bound <= wrap_last(haddr_s, hsize_s, hburst_s);
      if (accept)
      begin
        hold_trans  <= htrans_s;
        hold_addr   <= haddr_s;
        hold_write  <= hwrite_s;
        hold_size   <= hsize_s;
        hold_burst  <= hburst_s;
        hold_prot   <= hprot_s;
        hold_master <= hmaster_s;
        hold_lock   <= hmastlock_s;
      end
    end
  end

  task automatic report_mismatch(input string msg);
    err_cnt = err_cnt + 1;
    $display("MISMATCH at time %0t: %s", $time, msg);
  endtask

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  a_idle_resp : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !exp_data |-> (hreadyout_s && hresp_s == RSP_OKAY))
    else report_mismatch("idle data phase not ready with OKAY");
  a_idle_req : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (!accept && !exp_pend) |-> !held_tran_ip)
    else report_mismatch("held_tran_ip high with nothing to request");
  a_pass : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (accept && active_ip && !exp_pend && htrans_s == TRN_NONSEQ) |->
      (held_tran_ip && sel_ip && addr_ip == haddr_s && trans_ip == htrans_s &&
       write_ip == hwrite_s && size_ip == hsize_s && burst_ip == hburst_s &&
       prot_ip == hprot_s && master_ip == hmaster_s && mastlock_ip == hmastlock_s))
    else report_mismatch("pass-through transfer changed on its way out");
  a_data_resp : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (exp_data && !exp_pend) |-> (hreadyout_s == readyout_ip && hresp_s == resp_ip))
    else report_mismatch("data phase response does not follow the slave");
  a_hold : assert property (@(posedge HCLK) disable iff (!HRESETn)
    exp_pend |-> (held_tran_ip && sel_ip && trans_ip == TRN_NONSEQ &&
                  addr_ip == hold_addr && write_ip == hold_write &&
                  size_ip == hold_size && prot_ip == hold_prot &&
                  master_ip == hold_master && mastlock_ip == hold_lock))
    else report_mismatch("replayed transfer differs from the captured one");
  a_stall : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (exp_pend && exp_data) |-> (!hreadyout_s && hresp_s == RSP_OKAY))
    else report_mismatch("master not stalled while a transfer is held");
  a_ovr_incr : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (exp_ovr && src_type != TRN_NONSEQ) |-> burst_ip == BUR_INCR)
    else report_mismatch("broken burst not turned into INCR");
  a_burst_keep : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !exp_ovr |-> burst_ip == (exp_pend ? hold_burst : hburst_s))
    else report_mismatch("burst type changed without an override");
  a_wrap : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (exp_ovr && exp_bound) |->
      trans_ip == ((cur_trans == TRN_SEQ)  ? TRN_NONSEQ :
                   (cur_trans == TRN_BUSY) ? TRN_IDLE : cur_trans))
    else report_mismatch("transfer type not rewritten at the wrap point");
  a_trans_keep : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !(exp_ovr && exp_bound) |-> trans_ip == cur_trans)
    else report_mismatch("transfer type rewritten away from the wrap point");

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  task automatic next_cycle();
    @(posedge HCLK);
    #2;  // Inputs move just after the edge
  endtask

  task automatic drive_beat(input logic sel, input logic [TRANS_W-1:0] trans,
                            input logic [ADDR_W-1:0] addr, input logic write,
                            input logic [SIZE_W-1:0] size, input logic [BURST_W-1:0] burst);
    hsel_s      = sel;
    htrans_s    = trans;
    haddr_s     = addr;
    hwrite_s    = write;
    hsize_s     = size;
    hburst_s    = burst;
    hprot_s     = PROT_W'($urandom);
    hmaster_s   = MASTER_W'($urandom);
    hmastlock_s = 1'($urandom);  // Lock toggles too
  endtask

  task automatic set_port(input logic ready, input logic active, input logic slave_ready,
                          input logic [RESP_W-1:0] resp);
    hready_s    = ready;
    active_ip   = active;
    readyout_ip = slave_ready;
    resp_ip     = resp;
  endtask

  // Step until the master sees hreadyout_s high again
  task automatic wait_hready(input string label);
    int n;
    n = 0;
    next_cycle();
    while (!hreadyout_s && n < 16)
    begin
      next_cycle();
      n = n + 1;
    end
    if (!hreadyout_s)
    begin
      $display("Timeout: hreadyout_s stayed low too long during %s", label);
      $display("TB FAILED");
      $finish;
    end
  endtask

  task automatic finish_test(input string name);
    test_cnt = test_cnt + 1;
    if (err_cnt == errs_at_start)
      $display("test %0d %s: ok", test_cnt, name);
    else
    begin
      fail_cnt = fail_cnt + 1;
      $display("test %0d %s: FAIL with %0d errors", test_cnt, name, err_cnt - errs_at_start);
    end
  endtask

  initial
  begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;
  end

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  initial
  begin
    void'($urandom(89));
    HRESETn = 1'b0;
    drive_beat(1'b0, TRN_IDLE, '0, 1'b0, 3'd2, BUR_SINGLE);
    set_port(1'b1, 1'b0, 1'b1, RSP_OKAY);
    repeat (2) @(posedge HCLK);
    #2;
    HRESETn = 1'b1;

    errs_at_start = err_cnt;  // Unselected, IDLE and BUSY beats
    drive_beat(1'b0, TRN_NONSEQ, $urandom, 1'b1, 3'd2, BUR_SINGLE);
    set_port(1'b1, 1'b1, 1'b1, RSP_OKAY);
    next_cycle();
    drive_beat(1'b1, TRN_IDLE, $urandom, 1'b0, 3'd2, BUR_SINGLE);
    next_cycle();
    drive_beat(1'b1, TRN_BUSY, $urandom, 1'b0, 3'd2, BUR_INCR);
    next_cycle();
    next_cycle();
    finish_test("reset and idle");

    errs_at_start = err_cnt;
    drive_beat(1'b1, TRN_NONSEQ, $urandom, 1'b1, 3'd1, BUR_SINGLE);
    next_cycle();
    drive_beat(1'b1, TRN_IDLE, $urandom, 1'b0, 3'd2, BUR_SINGLE);
    set_port(1'b0, 1'b1, 1'b0, RSP_OKAY);  // Slave inserts a wait
    next_cycle();
    set_port(1'b1, 1'b1, 1'b1, RSP_ERROR);
    next_cycle();
    set_port(1'b1, 1'b1, 1'b1, RSP_OKAY);
    next_cycle();
    finish_test("pass-through");

    errs_at_start = err_cnt;
    drive_beat(1'b1, TRN_NONSEQ, $urandom, 1'b0, 3'd0, BUR_SINGLE);
    set_port(1'b1, 1'b0, 1'b1, RSP_OKAY);  // Output stage serving another port
    next_cycle();
    drive_beat(1'b1, TRN_IDLE, $urandom, 1'b0, 3'd2, BUR_SINGLE);
    set_port(1'b0, 1'b0, 1'b1, RSP_OKAY);
    next_cycle();
    next_cycle();
    set_port(1'b0, 1'b1, 1'b0, RSP_OKAY);  // Taken but slave not ready
    next_cycle();
    set_port(1'b0, 1'b1, 1'b1, RSP_OKAY);
    wait_hready("hold and replay");
    set_port(1'b1, 1'b0, 1'b1, RSP_OKAY);
    next_cycle();
    finish_test("hold and replay");

    errs_at_start = err_cnt;
    drive_beat(1'b1, TRN_NONSEQ, 32'h0000_0100, 1'b1, 3'd2, BUR_INCR4);
    set_port(1'b1, 1'b1, 1'b1, RSP_OKAY);
    next_cycle();
    drive_beat(1'b1, TRN_SEQ, 32'h0000_0104, 1'b1, 3'd2, BUR_INCR4);
    set_port(1'b1, 1'b0, 1'b1, RSP_OKAY);  // SEQ held, burst now broken
    next_cycle();
    drive_beat(1'b1, TRN_SEQ, 32'h0000_0108, 1'b1, 3'd2, BUR_INCR4);
    set_port(1'b0, 1'b1, 1'b1, RSP_OKAY);
    wait_hready("burst override");
    set_port(1'b1, 1'b1, 1'b1, RSP_OKAY);
    next_cycle();
    drive_beat(1'b1, TRN_NONSEQ, 32'h0000_0200, 1'b0, 3'd2, BUR_INCR4);
    next_cycle();
    drive_beat(1'b1, TRN_IDLE, 32'h0000_0204, 1'b0, 3'd2, BUR_INCR8);
    next_cycle();
    finish_test("burst override");

    errs_at_start = err_cnt;
    drive_beat(1'b1, TRN_NONSEQ, 32'h0000_0300, 1'b0, 3'd2, BUR_WRAP4);
    next_cycle();
    drive_beat(1'b1, TRN_SEQ, 32'h0000_0304, 1'b0, 3'd2, BUR_WRAP4);
    set_port(1'b1, 1'b0, 1'b1, RSP_OKAY);
    next_cycle();
    drive_beat(1'b1, TRN_SEQ, 32'h0000_0308, 1'b0, 3'd2, BUR_WRAP4);
    set_port(1'b0, 1'b1, 1'b1, RSP_OKAY);
    wait_hready("wrap boundary");
    set_port(1'b1, 1'b1, 1'b1, RSP_OKAY);
    next_cycle();
    drive_beat(1'b1, TRN_SEQ, 32'h0000_030C, 1'b0, 3'd2, BUR_WRAP4);  // Last word
    next_cycle();
    drive_beat(1'b1, TRN_BUSY, 32'h0000_0300, 1'b0, 3'd2, BUR_WRAP4);
    next_cycle();
    drive_beat(1'b1, TRN_SEQ, 32'h0000_0300, 1'b0, 3'd2, BUR_WRAP4);
    next_cycle();
    drive_beat(1'b1, TRN_IDLE, 32'h0000_0304, 1'b0, 3'd2, BUR_SINGLE);
    next_cycle();
    next_cycle();
    finish_test("wrap boundary");

    $display("tests %0d, failed %0d, mismatches %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// File: all.f
ahb_in_pkg.sv
ahb_hold_if.sv
ahb_pend_ctrl.sv
ahb_hold_reg.sv
ahb_burst_fix.sv
ahb_input_stage.sv
tb_ahb_input_stage.sv

// File: Bender.yml
package:
  name: ahb_input_stage

sources:
  - ahb_in_pkg.sv
  - ahb_hold_if.sv
  - ahb_pend_ctrl.sv
  - ahb_hold_reg.sv
  - ahb_burst_fix.sv
  - ahb_input_stage.sv
  - target: test
    files:
      - tb_ahb_input_stage.sv
